//--- logic/usb_link_pkg.sv
// USB link monitor package with state, detector and register enums plus timing defaults
`default_nettype none

package usb_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // Link state encodings
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    LinkDisconnected     = 3'd0,
    LinkPowered          = 3'd1,
    LinkPoweredSuspended = 3'd2,
    LinkActive           = 3'd3,
    LinkSuspended        = 3'd4,
    LinkActiveNoSOF      = 3'd5,
    LinkResuming         = 3'd6
  } link_state_e;

  // Bus reset detector
  typedef enum logic [1:0] {
    NoRst,
    RstCnt,
    RstPend
  } rst_state_e;

  // Bus inactivity detector
  typedef enum logic [1:0] {
    Active,
    InactCnt,
    InactPend
  } inac_state_e;

  // Register map
  typedef enum logic [1:0] {
    RegCtrl    = 2'd0,
    RegStatus  = 2'd1,
    RegEvent   = 2'd2,
    RegSofMiss = 2'd3
  } reg_addr_e;

  //////////////////////////////////////////////////////////////////////
  // Timing defaults
  //////////////////////////////////////////////////////////////////////
  parameter int unsigned DefClkPerUs     = 48;
  parameter int unsigned DefFilterCycles = 6;
  // Spec allows 2.5us to 10ms of SE0 for reset
  parameter int unsigned DefResetUs      = 3;
  // 3ms of idle J means suspend
  parameter int unsigned DefSuspendUs    = 3000;
  // 1ms frame plus margin for host clock tolerance
  parameter int unsigned DefSofUs        = 1005;

endpackage

`default_nettype wire

//--- logic/usb_link_evt_if.sv
// Bus event interface between the reset/idle detector and the link state machine
`timescale 1ns/1ps
`default_nettype none

interface usb_link_evt_if;

  // Pulse at end of a qualified bus reset
  logic ev_reset;
  // Level while a qualified reset is still on the bus
  logic link_reset;
  // Pulse when the idle timeout expires
  logic ev_bus_inactive;
  // Level from the state machine enabling idle monitoring
  logic monitor_inac;

  modport det_mp (
    output ev_reset,
    output link_reset,
    output ev_bus_inactive,
    input  monitor_inac
  );

  modport fsm_mp (
    input  ev_reset,
    input  link_reset,
    input  ev_bus_inactive,
    output monitor_inac
  );

endinterface

`default_nettype wire

//--- logic/usb_us_tick.sv
// Microsecond tick generator, divides the system clock down to one pulse per us
`timescale 1ns/1ps
`default_nettype none

module usb_us_tick #(
  parameter int unsigned ClkPerUs = usb_link_pkg::DefClkPerUs
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  output logic tick_o
);

  localparam int unsigned CntW = (ClkPerUs > 1) ? $clog2(ClkPerUs) : 1;

  logic [CntW-1:0] cnt_q;
  logic            wrap;

  // Last count of the period
  assign wrap = (cnt_q == CntW'(ClkPerUs - 1));

  // Tick registered on the wrap, so first pulse lands ClkPerUs cycles out
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      cnt_q  <= wrap ? '0 : cnt_q + 1'b1;
      tick_o <= wrap;
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_line_filter.sv
// Glitch filter, passes a level on only after it has held for a set number of cycles
`timescale 1ns/1ps
`default_nettype none

module usb_line_filter #(
  parameter int unsigned FilterCycles = usb_link_pkg::DefFilterCycles
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic filter_i,
  output logic filter_o
);

  localparam int unsigned CntW = $clog2(FilterCycles + 1);

  logic            sample_q;
  logic [CntW-1:0] stable_cnt_q;
  logic [CntW-1:0] stable_cnt_d;
  logic            stable;

  // Input matches what we saw last cycle
  assign stable = (filter_i == sample_q);

  // Restart on any change, saturate at the threshold
  always_comb begin
    if (!stable) begin
      stable_cnt_d = '0;
    end else if (stable_cnt_q == CntW'(FilterCycles)) begin
      stable_cnt_d = stable_cnt_q;
    end else begin
      stable_cnt_d = stable_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sample_q     <= 1'b0;
      stable_cnt_q <= '0;
      filter_o     <= 1'b0;
    end else begin
      sample_q     <= filter_i;
      stable_cnt_q <= stable_cnt_d;
      // Output follows once the level has survived the full window
      if (stable_cnt_d == CntW'(FilterCycles)) begin
        filter_o <= sample_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_bus_event_det.sv
// Bus reset and bus inactivity detector, both timed in microsecond ticks
`timescale 1ns/1ps
`default_nettype none

module usb_bus_event_det #(
  parameter int unsigned ResetUs   = usb_link_pkg::DefResetUs,
  parameter int unsigned SuspendUs = usb_link_pkg::DefSuspendUs
) (
  input  logic           clk_48mhz_i,
  input  logic           rst_ni,
  input  logic           us_tick_i,
  input  logic           se0_i,
  input  logic           rx_idle_det_i,
  usb_link_evt_if.det_mp evt
);

  import usb_link_pkg::*;

  localparam int unsigned RstW  = $clog2(ResetUs + 1);
  localparam int unsigned InacW = $clog2(SuspendUs + 1);

  rst_state_e       rst_state_q, rst_state_d;
  logic [RstW-1:0]  rst_timer_q, rst_timer_d;
  inac_state_e      inac_state_q, inac_state_d;
  logic [InacW-1:0] inac_timer_q, inac_timer_d;

  //////////////////////////////////////////////////////////////////////
  // Bus reset detection
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    rst_state_d    = rst_state_q;
    rst_timer_d    = rst_timer_q;
    evt.ev_reset   = 1'b0;
    evt.link_reset = 1'b0;
    unique case (rst_state_q)
      // Idle bus, wait for SE0
      NoRst: begin
        if (se0_i) begin
          rst_state_d = RstCnt;
          rst_timer_d = '0;
        end
      end
      // SE0 seen, count ticks and give up if it ends early
      RstCnt: begin
        if (!se0_i) begin
          rst_state_d = NoRst;
        end else if (us_tick_i) begin
          if (rst_timer_q == RstW'(ResetUs)) begin
            rst_state_d = RstPend;
          end else begin
            rst_timer_d = rst_timer_q + 1'b1;
          end
        end
      end
      // Qualified reset, event fires on the falling edge of SE0
      RstPend: begin
        evt.link_reset = 1'b1;
        if (!se0_i) begin
          rst_state_d  = NoRst;
          evt.ev_reset = 1'b1;
        end
      end
      default: rst_state_d = NoRst;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Bus inactivity detection
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    inac_state_d        = inac_state_q;
    inac_timer_d        = inac_timer_q;
    evt.ev_bus_inactive = 1'b0;
    unique case (inac_state_q)
      // Bus busy or monitoring off
      Active: begin
        inac_timer_d = '0;
        if (rx_idle_det_i && evt.monitor_inac) begin
          inac_state_d = InactCnt;
        end
      end
      // Idle, count toward the suspend timeout
      InactCnt: begin
        if (!rx_idle_det_i || !evt.monitor_inac) begin
          inac_state_d = Active;
        end else if (us_tick_i) begin
          if (inac_timer_q == InacW'(SuspendUs - 1)) begin
            inac_state_d        = InactPend;
            evt.ev_bus_inactive = 1'b1;
          end else begin
            inac_timer_d = inac_timer_q + 1'b1;
          end
        end
      end
      // Timeout reported, park until activity
      InactPend: begin
        if (!rx_idle_det_i || !evt.monitor_inac) begin
          inac_state_d = Active;
        end
      end
      default: inac_state_d = Active;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_state_q  <= NoRst;
      rst_timer_q  <= '0;
      inac_state_q <= Active;
      inac_timer_q <= '0;
    end else begin
      rst_state_q  <= rst_state_d;
      rst_timer_q  <= rst_timer_d;
      inac_state_q <= inac_state_d;
      inac_timer_q <= inac_timer_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_linkstate.sv
// USB device link state machine with SOF watchdog and host loss detection
`timescale 1ns/1ps
`default_nettype none

module usb_linkstate #(
  parameter int unsigned SofUs = usb_link_pkg::DefSofUs
) (
  input  logic                      clk_48mhz_i,
  input  logic                      rst_ni,
  input  logic                      us_tick_i,
  input  logic                      sense_i,
  input  logic                      pullup_en_i,
  input  logic                      rx_j_det_i,
  input  logic                      rx_idle_det_i,
  input  logic                      sof_detected_i,
  input  logic                      resume_req_i,
  usb_link_evt_if.fsm_mp            evt,
  output usb_link_pkg::link_state_e link_state_o,
  output logic                      link_disconnect_o,
  output logic                      link_powered_o,
  output logic                      link_active_o,
  output logic                      link_suspend_o,
  output logic                      link_reset_o,
  output logic                      link_resume_o,
  output logic                      host_lost_o,
  output logic                      sof_missed_o
);

  import usb_link_pkg::*;

  localparam int unsigned SofW = $clog2(SofUs + 1);

  link_state_e     state_q, state_d;
  logic            bus_active;
  logic [2:0]      missed_cnt_q;
  logic [SofW-1:0] sof_timer_q;

  // Anything but idle counts as bus activity
  assign bus_active = !rx_idle_det_i;

  // Status levels
  assign link_state_o      = state_q;
  assign link_disconnect_o = (state_q == LinkDisconnected);
  assign link_powered_o    = sense_i;
  assign link_active_o     = (state_q == LinkActive) || (state_q == LinkActiveNoSOF);
  assign link_suspend_o    = (state_q == LinkSuspended) || (state_q == LinkPoweredSuspended);
  assign link_reset_o      = evt.link_reset;

  // Watch for idle only in states that can drop into suspend
  assign evt.monitor_inac = sense_i && ((state_q == LinkPowered) || link_active_o);

  //////////////////////////////////////////////////////////////////////
  // Link state machine
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d       = state_q;
    link_resume_o = 1'b0;
    // VBUS or pull-up gone means detached
    if (!sense_i || !pullup_en_i) begin
      state_d = LinkDisconnected;
    end else begin
      unique case (state_q)
        LinkDisconnected: state_d = LinkPowered;
        LinkPowered: begin
          if (evt.ev_reset) begin
            state_d = LinkActiveNoSOF;
          end else if (resume_req_i) begin
            // Software restart of a link that was suspended while we were off
            state_d = LinkResuming;
          end else if (evt.ev_bus_inactive) begin
            state_d = LinkPoweredSuspended;
          end
        end
        LinkPoweredSuspended: begin
          if (evt.ev_reset) begin
            state_d = LinkActiveNoSOF;
          end else if (bus_active) begin
            link_resume_o = 1'b1;
            state_d       = LinkPowered;
          end
        end
        // Hold until resume signaling ends with a J or the host resets
        LinkResuming: begin
          if (rx_j_det_i || evt.ev_reset) begin
            link_resume_o = 1'b1;
            state_d       = LinkActiveNoSOF;
          end
        end
        LinkActiveNoSOF: begin
          if (evt.ev_bus_inactive) begin
            state_d = LinkSuspended;
          end else if (sof_detected_i) begin
            state_d = LinkActive;
          end
        end
        LinkActive: begin
          if (evt.ev_bus_inactive) begin
            state_d = LinkSuspended;
          end else if (evt.ev_reset) begin
            state_d = LinkActiveNoSOF;
          end
        end
        LinkSuspended: begin
          if (evt.ev_reset) begin
            link_resume_o = 1'b1;
            state_d       = LinkActiveNoSOF;
          end else if (bus_active) begin
            state_d = LinkResuming;
          end
        end
        default: state_d = LinkDisconnected;
      endcase
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LinkDisconnected;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // SOF watchdog
  //////////////////////////////////////////////////////////////////////
  // Frame considered missed once the timer hits its limit
  assign sof_missed_o = (sof_timer_q == SofW'(SofUs));
  // Fourth consecutive miss sets the top bit
  assign host_lost_o  = missed_cnt_q[2];

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sof_timer_q  <= '0;
      missed_cnt_q <= '0;
    end else begin
      if (sof_missed_o || sof_detected_i || !link_active_o || evt.link_reset) begin
        sof_timer_q <= '0;
      end else if (us_tick_i) begin
        sof_timer_q <= sof_timer_q + 1'b1;
      end
      // Saturates at 4
      if (sof_detected_i || !link_active_o || evt.link_reset) begin
        missed_cnt_q <= '0;
      end else if (sof_missed_o && !host_lost_o) begin
        missed_cnt_q <= missed_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_link_cfg.sv
// Link register block with control bits, sticky event flags and missed SOF count
`timescale 1ns/1ps
`default_nettype none

module usb_link_cfg (
  input  logic                      clk_48mhz_i,
  input  logic                      rst_ni,
  input  logic                      reg_we_i,
  input  logic [1:0]                reg_addr_i,
  input  logic [7:0]                reg_wdata_i,
  output logic [7:0]                reg_rdata_o,
  output logic                      pullup_en_o,
  output logic                      resume_req_o,
  input  usb_link_pkg::link_state_e link_state_i,
  input  logic                      link_disconnect_i,
  input  logic                      link_powered_i,
  input  logic                      link_reset_i,
  input  logic                      link_active_i,
  input  logic                      link_suspend_i,
  input  logic                      host_lost_i,
  input  logic                      link_resume_i,
  input  logic                      sof_missed_i
);

  import usb_link_pkg::*;

  logic       ctrl_we, evt_we;
  logic       host_lost_q, link_reset_q;
  logic [3:0] evt_q, evt_set;
  logic [7:0] sof_miss_cnt_q;

  assign ctrl_we = reg_we_i && (reg_addr_i == RegCtrl);
  assign evt_we  = reg_we_i && (reg_addr_i == RegEvent);

  // Event sources, levels turned into edges
  assign evt_set = {host_lost_i && !host_lost_q,
                    link_reset_i && !link_reset_q,
                    link_resume_i,
                    sof_missed_i};

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pullup_en_o    <= 1'b0;
      resume_req_o   <= 1'b0;
      host_lost_q    <= 1'b0;
      link_reset_q   <= 1'b0;
      evt_q          <= '0;
      sof_miss_cnt_q <= '0;
    end else begin
      if (ctrl_we) begin
        pullup_en_o <= reg_wdata_i[0];
      end
      // Resume request is a single cycle strobe
      resume_req_o <= ctrl_we && reg_wdata_i[1];
      host_lost_q  <= host_lost_i;
      link_reset_q <= link_reset_i;
      // Write 1 to clear, a new event in the same cycle wins
      evt_q <= (evt_q & ~(evt_we ? reg_wdata_i[3:0] : 4'b0)) | evt_set;
      if (sof_missed_i && (sof_miss_cnt_q != 8'hff)) begin
        sof_miss_cnt_q <= sof_miss_cnt_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (reg_addr_i)
      RegCtrl:   reg_rdata_o = {7'b0, pullup_en_o};
      RegStatus: reg_rdata_o = {link_suspend_i, link_active_i, link_reset_i,
                                link_powered_i, link_disconnect_i, link_state_i};
      RegEvent:  reg_rdata_o = {4'b0, evt_q};
      default:   reg_rdata_o = sof_miss_cnt_q;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/usb_link_top.sv
// USB full-speed link monitor top, joins tick, filters, detector, link FSM and registers
`timescale 1ns/1ps
`default_nettype none

module usb_link_top #(
  parameter int unsigned ClkPerUs     = usb_link_pkg::DefClkPerUs,
  parameter int unsigned FilterCycles = usb_link_pkg::DefFilterCycles,
  parameter int unsigned ResetUs      = usb_link_pkg::DefResetUs,
  parameter int unsigned SuspendUs    = usb_link_pkg::DefSuspendUs,
  parameter int unsigned SofUs        = usb_link_pkg::DefSofUs
) (
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  logic       usb_sense_i,
  input  logic       usb_dp_i,
  input  logic       usb_dn_i,
  input  logic       usb_oe_i,
  input  logic       rx_idle_det_i,
  input  logic       rx_j_det_i,
  input  logic       sof_detected_i,
  input  logic       reg_we_i,
  input  logic [1:0] reg_addr_i,
  input  logic [7:0] reg_wdata_i,
  output logic [7:0] reg_rdata_o,
  output logic [2:0] link_state_o,
  output logic       sof_missed_o
);

  import usb_link_pkg::*;

  logic        us_tick, se0_raw, se0, sense;
  logic        pullup_en, resume_req;
  logic        disconnect, powered, active, suspend, link_reset, resume, host_lost;
  link_state_e link_state;

  usb_link_evt_if evt_if ();

  // SE0 only counts while we are not driving the bus ourselves
  assign se0_raw      = !usb_dp_i && !usb_dn_i && !usb_oe_i;
  assign link_state_o = link_state;

  usb_us_tick #(.ClkPerUs(ClkPerUs)) tick_i (
    .clk_48mhz_i, .rst_ni, .tick_o(us_tick)
  );

  usb_line_filter #(.FilterCycles(FilterCycles)) se0_filt_i (
    .clk_48mhz_i, .rst_ni, .filter_i(se0_raw), .filter_o(se0)
  );

  usb_line_filter #(.FilterCycles(FilterCycles)) sense_filt_i (
    .clk_48mhz_i, .rst_ni, .filter_i(usb_sense_i), .filter_o(sense)
  );

  usb_bus_event_det #(.ResetUs(ResetUs), .SuspendUs(SuspendUs)) det_i (
    .clk_48mhz_i, .rst_ni, .us_tick_i(us_tick), .se0_i(se0), .rx_idle_det_i,
    .evt(evt_if.det_mp)
  );

  usb_linkstate #(.SofUs(SofUs)) fsm_i (
    .clk_48mhz_i, .rst_ni, .us_tick_i(us_tick), .sense_i(sense),
    .pullup_en_i(pullup_en), .rx_j_det_i, .rx_idle_det_i, .sof_detected_i,
    .resume_req_i(resume_req), .evt(evt_if.fsm_mp), .link_state_o(link_state),
    .link_disconnect_o(disconnect), .link_powered_o(powered), .link_active_o(active),
    .link_suspend_o(suspend), .link_reset_o(link_reset), .link_resume_o(resume),
    .host_lost_o(host_lost), .sof_missed_o
  );

  usb_link_cfg cfg_i (
    .clk_48mhz_i, .rst_ni, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .pullup_en_o(pullup_en), .resume_req_o(resume_req), .link_state_i(link_state),
    .link_disconnect_i(disconnect), .link_powered_i(powered), .link_reset_i(link_reset),
    .link_active_i(active), .link_suspend_i(suspend), .host_lost_i(host_lost),
    .link_resume_i(resume), .sof_missed_i(sof_missed_o)
  );

endmodule

`default_nettype wire

//--- bench/usb_link_tb.sv
// USB link monitor testbench, replays the stimulus file and checks link state and registers
`timescale 1ns/1ps
`default_nettype none

module usb_link_tb;

  // Shortened timing so the suspend and SOF paths finish quickly
  localparam int unsigned ClkPerUs  = 4;
  localparam int unsigned SuspendUs = 40;
  localparam int unsigned SofUs     = 30;
  localparam int unsigned MaxSteps  = 128;
  // Random SOF gap is MinGapUs plus a 4 bit draw, always well below SofUs
  localparam int unsigned MinGapUs  = 5;
  localparam int unsigned MaxGapUs  = MinGapUs + 15;
  // Address of the missed SOF count register
  localparam logic [1:0]  SofMissAddr = 2'd3;

  typedef enum logic [3:0] {
    OpEnd        = 4'h0,
    OpDrive      = 4'h1,
    OpWrite      = 4'h2,
    OpWait       = 4'h3,
    OpCheckState = 4'h4,
    OpCheckReg   = 4'h5,
    OpSof        = 4'h6,
    OpSofTrain   = 4'h7,
    OpCheckFloor = 4'h8
  } op_e;

  logic            clk_48mhz;
  logic            rst_n;
  logic            usb_sense, usb_dp, usb_dn, usb_oe;
  logic            rx_idle_det, rx_j_det, sof_detected;
  logic            reg_we;
  logic [1:0]      reg_addr;
  logic [7:0]      reg_wdata;
  logic [7:0]      reg_rdata;
  logic [2:0]      link_state;
  logic            sof_missed;
  // Three words per step, opcode then value then expected
  logic [15:0]     stim_mem [0:3*MaxSteps-1];
  logic [15:0]     lfsr_q;
  longint unsigned watchdog_ns = 0;
  // Pulses seen on the SOF miss output since reset
  int unsigned     miss_pulses = 0;

  usb_link_top #(
    .ClkPerUs (ClkPerUs),
    .SuspendUs(SuspendUs),
    .SofUs    (SofUs)
  ) dut_i (
    .clk_48mhz_i   (clk_48mhz),
    .rst_ni        (rst_n),
    .usb_sense_i   (usb_sense),
    .usb_dp_i      (usb_dp),
    .usb_dn_i      (usb_dn),
    .usb_oe_i      (usb_oe),
    .rx_idle_det_i (rx_idle_det),
    .rx_j_det_i    (rx_j_det),
    .sof_detected_i(sof_detected),
    .reg_we_i      (reg_we),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .link_state_o  (link_state),
    .sof_missed_o  (sof_missed)
  );

  // 50 MHz stand-in for the 48 MHz clock
  always #10 clk_48mhz = ~clk_48mhz;

  // Each missed frame is a one cycle pulse
  always @(posedge clk_48mhz) begin
    if (sof_missed) begin
      miss_pulses++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch in %s: expected 0x%02h, actual 0x%02h",
                                 name, expected, actual));
    end
  endtask

  function automatic logic [15:0] stim_word(input int unsigned step, input int unsigned col);
    logic [8:0] addr;
    addr = 9'(3 * step + col);
    stim_word = stim_mem[addr];
  endfunction

  // 16 bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int unsigned n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Bits 0 sense, 1 dp, 2 dn, 3 oe, 4 rx idle, 5 rx J
  task automatic drive_lines(input logic [5:0] lines);
    usb_sense   = lines[0];
    usb_dp      = lines[1];
    usb_dn      = lines[2];
    usb_oe      = lines[3];
    rx_idle_det = lines[4];
    rx_j_det    = lines[5];
  endtask

  task automatic wait_us(input int unsigned us);
    repeat (us * ClkPerUs) @(negedge clk_48mhz);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk_48mhz);
    reg_we    = 1'b0;
  endtask

  // Read data is combinational, sampled mid low phase
  task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
    reg_addr = addr;
    #5;
    data = reg_rdata;
    @(negedge clk_48mhz);
  endtask

  task automatic pulse_sof();
    sof_detected = 1'b1;
    @(negedge clk_48mhz);
    sof_detected = 1'b0;
  endtask

  task automatic sof_train(input int unsigned count);
    int unsigned gap;
    for (int i = 0; i < count; i++) begin
      take_bits(4, gap);
      wait_us(gap + MinGapUs);
      pulse_sof();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin : watchdog
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the stimulus did not complete", watchdog_ns);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Step sequencer
  //////////////////////////////////////////////////////////////////////
  initial begin : main
    int unsigned     step;
    logic [15:0]     word;
    logic [15:0]     value;
    logic [15:0]     expected;
    logic [7:0]      rdata;
    longint unsigned budget_us;
    op_e             op;
    clk_48mhz    = 1'b0;
    rst_n        = 1'b0;
    // Idle J on the bus, no VBUS
    drive_lines(6'b000010);
    sof_detected = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = 2'd0;
    reg_wdata    = 8'h00;
    lfsr_q       = 16'd93;
    $readmemh("bench/usb_link_stimulus.txt", stim_mem);

    // Budget from the waits and worst case SOF trains
    budget_us = 0;
    step      = 0;
    word      = stim_word(0, 0);
    while ((step < MaxSteps) && (op_e'(word[3:0]) != OpEnd)) begin
      value = stim_word(step, 1);
      case (op_e'(word[3:0]))
        OpWait:     budget_us += longint'(value);
        OpSofTrain: budget_us += longint'(value) * longint'(MaxGapUs + 1);
        default:    budget_us += 64'd1;
      endcase
      step++;
      word = stim_word(step, 0);
    end
    if (step == 0) begin
      stop_with_failure("stimulus file holds no steps");
    end
    watchdog_ns = (budget_us * longint'(ClkPerUs) + 64'd200) * 64'd40;

    repeat (10) @(negedge clk_48mhz);
    rst_n = 1'b1;

    step = 0;
    word = stim_word(0, 0);
    op   = op_e'(word[3:0]);
    while (op != OpEnd) begin
      value    = stim_word(step, 1);
      expected = stim_word(step, 2);
      case (op)
        OpDrive:      drive_lines(value[5:0]);
        OpWrite:      write_reg(value[9:8], value[7:0]);
        OpWait:       wait_us(32'(value));
        OpCheckState: check_value($sformatf("step %0d link state", step), expected,
                                  {13'b0, link_state});
        OpCheckReg: begin
          read_reg(value[1:0], rdata);
          check_value($sformatf("step %0d register %0d", step, value[1:0]), expected,
                      {8'h00, rdata});
          // One pulse on the miss output for every count in the register
          if (value[1:0] == SofMissAddr) begin
            check_value($sformatf("step %0d SOF miss pulses", step), expected,
                        16'(miss_pulses));
          end
        end
        OpSof:        pulse_sof();
        OpSofTrain:   sof_train(32'(value));
        // Lower bound check that accepts any larger count
        OpCheckFloor: begin
          read_reg(value[1:0], rdata);
          check_value($sformatf("step %0d register %0d floor", step, value[1:0]), expected,
                      (rdata >= expected[7:0]) ? expected : {8'h00, rdata});
          if (value[1:0] == SofMissAddr) begin
            check_value($sformatf("step %0d SOF miss pulses floor", step), expected,
                        (miss_pulses >= 32'(expected)) ? expected : 16'(miss_pulses));
          end
        end
        default: stop_with_failure($sformatf("unknown opcode %0h at step %0d", op, step));
      endcase
      step++;
      if (step >= MaxSteps) begin
        stop_with_failure("stimulus file has no end marker");
      end
      word = stim_word(step, 0);
      op   = op_e'(word[3:0]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/usb_link_stimulus.txt
// Columns: opcode, value, expected (hex). Opcodes 1 drive lines, 2 write {addr,data},
// 3 wait us, 4 check state, 5 check reg, 6 SOF, 7 random SOF train, 8 reg floor, 0 end
// Line bits: 0 sense, 1 dp, 2 dn, 3 oe, 4 rx idle, 5 rx J
// Attach
4 0000 00
1 0003 00
3 0003 00
4 0000 00
5 0001 18
2 0001 00
3 0001 00
4 0000 01
5 0000 01
1 0002 00
3 0003 00
4 0000 00
1 0003 00
3 0003 00
4 0000 01
5 0001 11
// Bus reset of 8 us
1 0001 00
3 0008 00
1 0003 00
3 0003 00
4 0000 05
5 0002 04
2 020f 00
5 0002 00
// SE0 of 1 us is filtered, 3 us is abandoned by the counter
1 0001 00
3 0001 00
1 0003 00
3 0003 00
4 0000 05
1 0001 00
3 0003 00
1 0003 00
3 0003 00
4 0000 05
5 0002 00
// SOF and random SOF train
6 0000 00
4 0000 03
7 0008 00
4 0000 03
5 0003 00
5 0002 00
// Host loss after 140 us without SOF
3 008c 00
8 0003 04
5 0002 09
4 0000 03
2 020f 00
5 0002 00
6 0000 00
4 0000 03
// Suspend from active, then resume
1 0013 00
3 0024 00
4 0000 03
3 0009 00
4 0000 04
5 0001 94
2 020f 00
5 0002 00
1 0003 00
3 0001 00
4 0000 06
1 0023 00
3 0001 00
4 0000 05
5 0002 02
1 0003 00
// Suspend from powered
2 0000 00
3 0001 00
4 0000 00
2 0001 00
3 0001 00
4 0000 01
2 020f 00
5 0002 00
1 0013 00
3 002d 00
4 0000 02
5 0001 92
1 0003 00
3 0001 00
4 0000 01
5 0002 02
// Software resume from powered
2 0003 00
5 0000 01
3 0001 00
4 0000 06
1 0023 00
3 0001 00
4 0000 05
5 0001 55
0 0000 00

//--- flist.f
logic/usb_link_pkg.sv
logic/usb_link_evt_if.sv
logic/usb_us_tick.sv
logic/usb_line_filter.sv
logic/usb_bus_event_det.sv
logic/usb_linkstate.sv
logic/usb_link_cfg.sv
logic/usb_link_top.sv
bench/usb_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the USB link monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module usb_link_tb \
  --Mdir obj_dir -o usb_link_sim \
  && ./obj_dir/usb_link_sim | tee sim.log \
  || echo "run_sim: build or simulation stopped with an error"
grep -qx "Simulation finished: PASS" sim.log 2>/dev/null \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed, see sim.log"; exit 1; }
